/* include/stile_defs.svh */
// Width, depth and initial-value macros for the multiply tile
`ifndef STILE_DEFS_SVH
`define STILE_DEFS_SVH

// Weight buffer geometry
// One block RAM sized as 1024 words of 16 bits
`define STILE_W_WIDTH        16
`define STILE_W_ADDR_WIDTH   10
`define STILE_W_DEPTH        1024

// Activation buffer geometry
// Small distributed memory, written two words at a time
`define STILE_ACT_WIDTH      16
`define STILE_ACT_ADDR_WIDTH 6
`define STILE_ACT_DEPTH      64

// Result and cascade path
`define STILE_P_WIDTH        48   // Full accumulator width of the slice

// Power-up value of every weight word
// A weight of one makes the product equal the activation
`define STILE_W_INIT_WORD    1

`endif

/* source/stile_pkg.sv */
// Package of vector types for weights, activations, addresses and products
`default_nettype none

`include "stile_defs.svh"

package stile_pkg;

   // Weight side
   typedef logic signed [`STILE_W_WIDTH-1:0]      weight_t;       // Signed weight word
   typedef logic        [`STILE_W_ADDR_WIDTH-1:0] weight_addr_t;  // Weight memory index

   // Activation side
   typedef logic signed [`STILE_ACT_WIDTH-1:0]    act_t;          // Signed activation word

   // Two activation words in one write
   // Low half holds the even word
   typedef logic [2*`STILE_ACT_WIDTH-1:0]         act_pair_t;

   typedef logic [`STILE_ACT_ADDR_WIDTH-1:0]      act_addr_t;     // Word address

   // Pair address is the word address without its low bit
   typedef logic [`STILE_ACT_ADDR_WIDTH-2:0]      act_pair_addr_t;

   // Product, cascade input and result
   typedef logic signed [`STILE_P_WIDTH-1:0]      psum_t;

endpackage

`default_nettype wire

/* source/weight_buffer.sv */
// Weight memory with synchronous write port and two-stage registered read
`timescale 1ns/1ps
`default_nettype none

`include "stile_defs.svh"

module weight_buffer (
   input  wire logic                   clk_h,
   input  wire logic                   rst_n,
   // Write port
   input  wire stile_pkg::weight_t      wr_data,
   input  wire stile_pkg::weight_addr_t wr_addr,
   input  wire logic                   wr_en,
   // Read port
   input  wire stile_pkg::weight_addr_t rd_addr,
   output stile_pkg::weight_t          rd_data
);

   stile_pkg::weight_t      mem [`STILE_W_DEPTH];  // Weight storage
   stile_pkg::weight_addr_t rd_addr_q;              // Registered read address

   // Every word powers up to the same value
   // Matches the block RAM init contents
   initial begin
      for (int i = 0; i < `STILE_W_DEPTH; i++) begin
         mem[i] = stile_pkg::weight_t'(`STILE_W_INIT_WORD);
      end
   end

   // Write port
   always_ff @(posedge clk_h) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;  // Plain synchronous write
      end
   end

   // First read stage
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         rd_addr_q <= '0;
      end else begin
         rd_addr_q <= rd_addr;     // Sampled on every cycle
      end
   end

   // Second read stage
   // Reads from the registered address
   // Same-cycle write to that word is not seen yet, so old data comes out
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         rd_data <= '0;            // Output register clears
      end else begin
         rd_data <= mem[rd_addr_q];
      end
   end

endmodule

`default_nettype wire

/* source/act_buffer.sv */
// Activation memory with pair write, half-select flop and read alignment registers
`timescale 1ns/1ps
`default_nettype none

`include "stile_defs.svh"

module act_buffer (
   input  wire logic                     clk_h,
   input  wire logic                     rst_n,
   // Pair write port
   input  wire stile_pkg::act_pair_t      wr_data,
   input  wire stile_pkg::act_pair_addr_t wr_addr_hbit,
   input  wire logic                     wr_en,
   // Word read port
   input  wire stile_pkg::act_addr_t      rd_addr,
   output stile_pkg::act_t               rd_data
);

   stile_pkg::act_t      mem [`STILE_ACT_DEPTH];  // Activation storage
   logic                 half_sel;                 // 0 low half, 1 high half
   stile_pkg::act_addr_t wr_addr;                  // Full word write address
   stile_pkg::act_t      wr_word;                  // Half picked from the pair
   stile_pkg::act_t      rd_word;                  // Combinational read
   stile_pkg::act_t      rd_stage1;                // First alignment register

   // Half-select advances only on enabled cycles
   // Dropping wr_en restarts at the low half
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         half_sel <= 1'b0;
      end else if (wr_en) begin
         half_sel <= ~half_sel;   // Low then high then low again
      end else begin
         half_sel <= 1'b0;
      end
   end

   // Low address bit comes from the half-select
   assign wr_addr = {wr_addr_hbit, half_sel};

   // Even word from the low half and odd word from the high half
   assign wr_word = half_sel ? wr_data[`STILE_ACT_WIDTH +: `STILE_ACT_WIDTH]
                             : wr_data[0 +: `STILE_ACT_WIDTH];

   // Write port
   always_ff @(posedge clk_h) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_word;
      end
   end

   // Asynchronous read like a distributed RAM
   assign rd_word = mem[rd_addr];

   // Two registers so the word lines up with the weight read
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         rd_stage1 <= '0;
         rd_data   <= '0;
      end else begin
         rd_stage1 <= rd_word;     // Stands in for the address register
         rd_data   <= rd_stage1;   // Matches the weight output register
      end
   end

endmodule

`default_nettype wire

/* source/mac_slice.sv */
// Multiply stage with operand, product and result registers and cascade add
`timescale 1ns/1ps
`default_nettype none

module mac_slice (
   input  wire logic             clk_h,
   input  wire logic             rst_n,
   // Operands from the two buffers
   input  wire stile_pkg::weight_t weight,
   input  wire stile_pkg::act_t    act,
   // Cascade in from the previous slice
   input  wire stile_pkg::psum_t   p_casin,
   // Result and cascade out
   output stile_pkg::psum_t       p_out,
   output stile_pkg::psum_t       p_casout
);

   stile_pkg::weight_t weight_q;   // Operand register A side
   stile_pkg::act_t    act_q;      // Operand register B side
   stile_pkg::psum_t   prod_q;     // Multiplier output register
   stile_pkg::psum_t   prod_ext;   // Full-width signed product
   stile_pkg::psum_t   p_q;        // Result register

   // Operand stage
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         weight_q <= '0;
         act_q    <= '0;
      end else begin
         weight_q <= weight;
         act_q    <= act;
      end
   end

   // Both sides widened first so the multiply runs at 48 bits
   // Sign carried through by the signed casts
   assign prod_ext = stile_pkg::psum_t'(weight_q) * stile_pkg::psum_t'(act_q);

   // Product stage
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         prod_q <= '0;
      end else begin
         prod_q <= prod_ext;
      end
   end

   // Result stage
   // Cascade input is taken on the same edge that loads the result
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         p_q <= '0;
      end else begin
         p_q <= prod_q + p_casin;   // Wraps at 48 bits like the DSP
      end
   end

   assign p_out    = p_q;
   assign p_casout = p_q;          // Cascade copy of the result

endmodule

`default_nettype wire

/* source/super_tile.sv */
// Top level of the multiply tile joining weight buffer, activation buffer and multiply stage
`timescale 1ns/1ps
`default_nettype none

module super_tile (
   input  wire logic                     clk_h,
   input  wire logic                     rst_n,
   // Weight buffer write side
   // Kept for loading weights at run time
   input  wire stile_pkg::weight_t        w_wr_data,
   input  wire stile_pkg::weight_addr_t   w_wr_addr,
   input  wire logic                     w_wr_en,
   // Weight read address
   input  wire stile_pkg::weight_addr_t   w_rd_addr,
   // Activation pair write side
   input  wire stile_pkg::act_pair_t      act_wr_data,
   input  wire stile_pkg::act_pair_addr_t act_wr_addr_hbit,
   input  wire logic                     act_wr_en,
   // Activation read address
   input  wire stile_pkg::act_addr_t      act_rd_addr,
   // Cascade in
   input  wire stile_pkg::psum_t          p_casin,
   // Results
   output stile_pkg::psum_t              p_out,
   output stile_pkg::psum_t              p_casout
);

   stile_pkg::weight_t w_rd_data;     // Weight word toward the multiplier
   stile_pkg::act_t    act_rd_data;   // Activation word toward the multiplier

   // Weight memory
   // Address to data takes two edges
   weight_buffer weight_buffer_i (
      .clk_h   (clk_h),
      .rst_n   (rst_n),
      .wr_data (w_wr_data),
      .wr_addr (w_wr_addr),
      .wr_en   (w_wr_en),
      .rd_addr (w_rd_addr),
      .rd_data (w_rd_data)
   );

   // Activation memory
   // Padded to the same two-edge latency as the weight side
   act_buffer act_buffer_i (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .wr_data      (act_wr_data),
      .wr_addr_hbit (act_wr_addr_hbit),
      .wr_en        (act_wr_en),
      .rd_addr      (act_rd_addr),
      .rd_data      (act_rd_data)
   );

   // Multiply and cascade add
   // Three more edges to the result
   mac_slice mac_slice_i (
      .clk_h    (clk_h),
      .rst_n    (rst_n),
      .weight   (w_rd_data),
      .act      (act_rd_data),
      .p_casin  (p_casin),
      .p_out    (p_out),
      .p_casout (p_casout)
   );

endmodule

`default_nettype wire

/* tests/tb_checks.svh */
// Compare tasks for the product and cascade results, error counters and failure notes
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_count   = 0;   // Mismatches and other failures so far
int check_count = 0;   // Compares done so far

// Result register as seen on p_out
task automatic check_psum(input stile_pkg::psum_t exp_val,
                          input stile_pkg::psum_t got_val);
   check_count++;
   if (got_val !== exp_val) begin
      err_count++;
      $display("ERR %0t ns p_out expected %0d (0x%h) actual %0d (0x%h)",
               $time, exp_val, exp_val, got_val, got_val);
   end
endtask

// Cascade copy, held to the same expected value as p_out
task automatic check_casout(input stile_pkg::psum_t exp_val,
                            input stile_pkg::psum_t got_val);
   check_count++;
   if (got_val !== exp_val) begin
      err_count++;
      $display("ERR %0t ns p_casout expected %0d (0x%h) actual %0d (0x%h)",
               $time, exp_val, exp_val, got_val, got_val);
   end
endtask

// Failures that are not a wrong value
task automatic report_problem(input string what);
   err_count++;
   $display("Problem at %0t ns: %s", $time, what);
endtask

`endif

/* tests/tb_super_tile.sv */
// Testbench for the multiply tile with stimulus table, apply loop, timeout and report
`timescale 1ns/1ps
`default_nettype none

`include "stile_defs.svh"

module tb_super_tile;

   localparam int NUM_ROWS    = 28;
   localparam int CYCLE_LIMIT = NUM_ROWS * 12 + 50;   // Each row needs 7 cycles

   // Row kinds, one per checked behavior
   typedef enum logic [1:0] {KIND_INIT_W, KIND_RAND_W, KIND_PAIR, KIND_CASIN} kind_e;

   typedef struct packed {
      kind_e                     kind;
      logic                      w_wr;           // Row writes its weight first
      stile_pkg::weight_addr_t   w_addr;         // Write and read address
      stile_pkg::weight_t        w_data;
      logic                      act_wr;         // Row writes a whole pair
      stile_pkg::act_pair_addr_t act_pair_addr;
      stile_pkg::act_pair_t      act_data;
      stile_pkg::act_addr_t      act_rd_addr;
      stile_pkg::psum_t          casin;
      stile_pkg::psum_t          exp_p;          // Expected p_out and p_casout
   } row_t;

   logic                      clk_h;
   logic                      rst_n;
   stile_pkg::weight_t        w_wr_data;
   stile_pkg::weight_addr_t   w_wr_addr;
   logic                      w_wr_en;
   stile_pkg::weight_addr_t   w_rd_addr;
   stile_pkg::act_pair_t      act_wr_data;
   stile_pkg::act_pair_addr_t act_wr_addr_hbit;
   logic                      act_wr_en;
   stile_pkg::act_addr_t      act_rd_addr;
   stile_pkg::psum_t          p_casin;
   stile_pkg::psum_t          p_out;
   stile_pkg::psum_t          p_casout;

   row_t      rows [NUM_ROWS];
   bit [31:0] rng_state = 32'd92;   // Xorshift seed
   int        cycle_count;

   `include "tb_checks.svh"

   super_tile super_tile_i (
      .clk_h            (clk_h),
      .rst_n            (rst_n),
      .w_wr_data        (w_wr_data),
      .w_wr_addr        (w_wr_addr),
      .w_wr_en          (w_wr_en),
      .w_rd_addr        (w_rd_addr),
      .act_wr_data      (act_wr_data),
      .act_wr_addr_hbit (act_wr_addr_hbit),
      .act_wr_en        (act_wr_en),
      .act_rd_addr      (act_rd_addr),
      .p_casin          (p_casin),
      .p_out            (p_out),
      .p_casout         (p_casout)
   );

   initial begin
      clk_h = 1'b0;
      forever #2 clk_h = ~clk_h;   // 4 ns period
   end

   // 32-bit xorshift
   function automatic bit [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Signed product plus cascade, kept to 48 bits
   function automatic stile_pkg::psum_t expected_p(input stile_pkg::weight_t w,
                                                   input stile_pkg::act_t    a,
                                                   input stile_pkg::psum_t   c);
      longint sum;
      sum = longint'(w) * longint'(a) + longint'(c);
      return stile_pkg::psum_t'(sum[`STILE_P_WIDTH-1:0]);
   endfunction

   // Fill the table and work out each expected result
   // Lower half of the weight space is never written so it stays at the init word
   function automatic void build_table();
      bit [31:0]          r;
      bit [63:0]          r64;
      stile_pkg::weight_t w_val;
      stile_pkg::act_t    a_val;
      for (int i = 0; i < NUM_ROWS; i++) begin
         r = next_rand();
         rows[i].kind          = KIND_INIT_W;
         rows[i].w_wr          = 1'b0;
         rows[i].w_addr        = {1'b0, r[8:0]};
         rows[i].w_data        = stile_pkg::weight_t'(r[31:16]);
         rows[i].act_wr        = 1'b1;
         rows[i].act_pair_addr = r[13:9];
         rows[i].act_data      = next_rand();
         rows[i].act_rd_addr   = {r[13:9], r[14]};   // Either word of the pair
         rows[i].casin         = '0;
         if (i >= 6 && i < 14) begin
            rows[i].kind   = KIND_RAND_W;
            rows[i].w_wr   = 1'b1;
            rows[i].w_addr = {1'b1, r[8:0]};          // Upper half takes writes
         end else if (i >= 14 && i < 20) begin
            rows[i].kind = KIND_PAIR;
            if (i % 2 == 0) begin
               rows[i].act_rd_addr = {r[13:9], 1'b0};  // Even word first
            end else begin
               // Odd word of the pair written one row earlier
               rows[i].act_wr        = 1'b0;
               rows[i].act_pair_addr = rows[i-1].act_pair_addr;
               rows[i].act_data      = rows[i-1].act_data;
               rows[i].act_rd_addr   = {rows[i-1].act_pair_addr, 1'b1};
            end
         end else if (i >= 20) begin
            rows[i].kind   = KIND_CASIN;
            rows[i].w_wr   = 1'b1;
            rows[i].w_addr = {1'b1, r[8:0]};
            if (i % 2 == 0) begin
               rows[i].w_data[`STILE_W_WIDTH-1] = 1'b1;   // Negative weight
            end
            r64           = {next_rand(), next_rand()};
            rows[i].casin = stile_pkg::psum_t'(r64[`STILE_P_WIDTH-1:0]);
         end
         w_val = rows[i].w_wr ? rows[i].w_data
                              : stile_pkg::weight_t'(`STILE_W_INIT_WORD);
         // Low half of the pair is the even word
         a_val = rows[i].act_rd_addr[0]
                 ? stile_pkg::act_t'(rows[i].act_data[`STILE_ACT_WIDTH +: `STILE_ACT_WIDTH])
                 : stile_pkg::act_t'(rows[i].act_data[0 +: `STILE_ACT_WIDTH]);
         rows[i].exp_p = expected_p(w_val, a_val, rows[i].casin);
      end
   endfunction

   // Writes, then held read addresses, then the check 5 cycles on
   task automatic apply_row(input row_t r);
      w_wr_data        = r.w_data;
      w_wr_addr        = r.w_addr;
      w_wr_en          = r.w_wr;
      act_wr_data      = r.act_data;
      act_wr_addr_hbit = r.act_pair_addr;
      act_wr_en        = r.act_wr;
      @(posedge clk_h);
      #1;
      w_wr_en = 1'b0;       // Weight and low half written
      @(posedge clk_h);
      #1;
      act_wr_en   = 1'b0;   // High half written
      w_rd_addr   = r.w_addr;
      act_rd_addr = r.act_rd_addr;
      p_casin     = r.casin;
      repeat (5) @(posedge clk_h);
      #1;
      check_psum(r.exp_p, p_out);
      check_casout(r.exp_p, p_casout);
   endtask

   initial begin
      int errs_before;
      rst_n            = 1'b0;
      w_wr_data        = '0;
      w_wr_addr        = '0;
      w_wr_en          = 1'b0;
      w_rd_addr        = '0;
      act_wr_data      = '0;
      act_wr_addr_hbit = '0;
      act_wr_en        = 1'b0;
      act_rd_addr      = '0;
      p_casin          = '0;
      build_table();

      // Reset held for 4 cycles, results checked before data gets through
      repeat (4) @(posedge clk_h);
      #1;
      check_psum('0, p_out);
      check_casout('0, p_casout);
      rst_n = 1'b1;
      @(posedge clk_h);
      #1;
      check_psum('0, p_out);
      check_casout('0, p_casout);
      $display("Test 0 reset: %s", (err_count == 0) ? "ok" : "mismatch");

      for (int i = 0; i < NUM_ROWS; i++) begin
         errs_before = err_count;
         apply_row(rows[i]);
         $display("Test %0d %s: %s", i + 1, rows[i].kind.name(),
                  (err_count == errs_before) ? "ok" : "mismatch");
      end

      $display("Tests %0d, checks %0d, errors %0d", NUM_ROWS + 1, check_count, err_count);
      if (err_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog on the clock
   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk_h);
         cycle_count++;
      end
      report_problem($sformatf("run did not complete within %0d cycles", CYCLE_LIMIT));
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
+incdir+tests
source/stile_pkg.sv
source/weight_buffer.sv
source/act_buffer.sv
source/mac_slice.sv
source/super_tile.sv
tests/tb_super_tile.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the multiply tile testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --timescale 1ns/1ps \
   --top-module tb_super_tile \
   -f vlog.f

# Output is kept in a variable and shown in full
sim_out=$(./obj_dir/Vtb_super_tile)
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
   exit 0
else
   echo "Simulation reported failures"
   exit 1
fi
